// File: include/axi_xfer_settings.svh
`ifndef AXI_XFER_SETTINGS_SVH
`define AXI_XFER_SETTINGS_SVH

// Byte address width of the AXI bus
`define AXI_XFER_ADDR_W 32

// Data bus width in bits
// Any power of two from 32 upwards
`define AXI_XFER_DATA_W 32

// Byte length field of a user command
`define AXI_XFER_LEN_W 16

// AWLEN field, beats minus one
`define AXI_XFER_AXLEN_W 8

// Word and beat counters
`define AXI_XFER_CNT_W 16

`endif

// File: hdl/axi_xfer_pkg.sv
`include "axi_xfer_settings.svh"

package axi_xfer_pkg;

   localparam int DATA_W   = `AXI_XFER_DATA_W;
   localparam int STRB_W   = DATA_W / 8;      // Byte lanes per word
   localparam int OFFSET_W = $clog2(STRB_W);  // Lane index bits

   typedef logic [`AXI_XFER_ADDR_W-1:0]  addr_t;    // Byte address
   typedef logic [`AXI_XFER_LEN_W-1:0]   len_t;     // Byte count
   typedef logic [DATA_W-1:0]            data_t;    // One bus word
   typedef logic [STRB_W-1:0]            strb_t;    // One bit per byte lane
   typedef logic [`AXI_XFER_AXLEN_W-1:0] axlen_t;   // Beats minus one
   typedef logic [`AXI_XFER_CNT_W-1:0]   cnt_t;     // Words or beats
   typedef logic [OFFSET_W-1:0]          offset_t;  // Lane within a word
   typedef logic [1:0]                   resp_t;    // BRESP code

   typedef struct packed {
      addr_t addr;
      len_t  len;
   } xfer_cmd_t;

   typedef struct packed {
      addr_t  addr;  // Word aligned
      axlen_t len;
      logic   last;  // Burst closes the transfer
   } burst_info_t;

   typedef struct packed {
      addr_t      addr;
      axlen_t     len;
      logic [2:0] size;
      logic [1:0] burst;
   } aw_beat_t;

   typedef struct packed {
      offset_t offset;        // Destination lane of the first byte
      strb_t   initial_strb;  // Strobe of beat 0
      strb_t   final_strb;    // Strobe of the last beat
      cnt_t    src_words;     // Words read from the source
      cnt_t    axi_beats;     // Beats written on W
      logic    extra_beat;    // One beat more than source words
   } xfer_geom_t;

   typedef enum logic [2:0] {IDLE, CALC, ADDR, DATA, RESP} seq_state_t;

   localparam logic [2:0] AXSIZE_FULL = 3'(OFFSET_W);  // Full bus width per beat
   localparam logic [1:0] BURST_INCR  = 2'b01;

endpackage

// File: hdl/axi_transfer_ctrl.sv
`timescale 1ns/1ps

`include "axi_xfer_settings.svh"

module axi_transfer_ctrl (
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      xfer_start_i,  // Command accepted
   input  logic                      burst_adv_i,   // Current burst issued on AW
   input  axi_xfer_pkg::xfer_cmd_t   cmd_i,
   output axi_xfer_pkg::burst_info_t burst_o,
   output axi_xfer_pkg::xfer_geom_t  geom_o
);

   import axi_xfer_pkg::*;

   // One bit wider than a length so offset plus length cannot wrap
   typedef logic [`AXI_XFER_LEN_W:0] span_t;

   localparam span_t MAX_BURST_B = span_t'((2 ** `AXI_XFER_AXLEN_W) * STRB_W);
   localparam span_t PAGE_B      = span_t'(4096);
   localparam span_t LANE_MASK   = span_t'(STRB_W - 1);

   xfer_cmd_t cmd_q;       // Command as accepted
   addr_t     cur_addr_q;  // Aligned start of the pending burst
   len_t      rem_len_q;   // User bytes not yet covered by a burst
   logic      first_q;     // Pending burst is the first one

   span_t     page_room;    // Bytes up to the next 4 KB page
   span_t     burst_cap;    // Bytes one burst may span
   span_t     lead;         // Unused lanes ahead of the first byte
   span_t     avail;        // User bytes that fit in this burst
   span_t     take;         // User bytes this burst writes
   span_t     burst_bytes;  // Bus bytes this burst spans
   span_t     burst_beats;

   offset_t   cmd_off;
   span_t     span;         // Offset plus length
   offset_t   end_lane;     // Lane after the last byte, zero when full
   strb_t     init_strb;
   strb_t     fin_strb;
   cnt_t      src_words;
   cnt_t      axi_beats;

   // Burst size
   // Only the first burst carries the lane offset
   always_comb begin
      page_room = PAGE_B - span_t'(cur_addr_q[11:0]);
      burst_cap = (page_room < MAX_BURST_B) ? page_room : MAX_BURST_B;

      lead  = first_q ? span_t'(cmd_q.addr[OFFSET_W-1:0]) : '0;
      avail = burst_cap - lead;  // Never zero, start is word aligned

      if (span_t'(rem_len_q) < avail) begin
         take = span_t'(rem_len_q);
      end else begin
         take = avail;
      end

      burst_bytes = (lead + take + LANE_MASK) & ~LANE_MASK;  // Round up to whole beats
      burst_beats = burst_bytes >> OFFSET_W;
   end

   assign burst_o.addr = cur_addr_q;
   assign burst_o.len  = axlen_t'(burst_beats - span_t'(1));
   assign burst_o.last = (take == span_t'(rem_len_q));  // Nothing left after this one

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         cur_addr_q <= '0;
         rem_len_q  <= '0;
         first_q    <= 1'b0;
      end else if (xfer_start_i) begin
         cur_addr_q <= cmd_i.addr & ~addr_t'(STRB_W - 1);  // Drop lane bits
         rem_len_q  <= cmd_i.len;
         first_q    <= 1'b1;
      end else if (burst_adv_i) begin
         cur_addr_q <= cur_addr_q + addr_t'(burst_bytes);  // Next burst starts right after
         rem_len_q  <= rem_len_q - len_t'(take);
         first_q    <= 1'b0;
      end
   end

   // Whole transfer shape follows from the command alone
   always_ff @(posedge clk_i) begin
      if (xfer_start_i) begin
         cmd_q <= cmd_i;
      end
   end

   assign cmd_off  = cmd_q.addr[OFFSET_W-1:0];
   assign span     = span_t'(cmd_off) + span_t'(cmd_q.len);
   assign end_lane = span[OFFSET_W-1:0];

   // Lane masks for the edge beats
   // A single beat transfer is cut on both sides by the aligner
   always_comb begin
      for (int i = 0; i < STRB_W; i++) begin
         init_strb[i] = (span_t'(i) >= span_t'(cmd_off)) && (span_t'(i) < span);
         fin_strb[i]  = (end_lane == '0) || (offset_t'(i) < end_lane);
      end
   end

   assign src_words = cnt_t'((span_t'(cmd_q.len) + LANE_MASK) >> OFFSET_W);
   assign axi_beats = cnt_t'((span + LANE_MASK) >> OFFSET_W);  // Offset may spill a word

   assign geom_o.offset       = cmd_off;
   assign geom_o.initial_strb = init_strb;
   assign geom_o.final_strb   = fin_strb;
   assign geom_o.src_words    = src_words;
   assign geom_o.axi_beats    = axi_beats;
   assign geom_o.extra_beat   = (axi_beats != src_words);

endmodule

// File: hdl/axi_write_aligner.sv
`timescale 1ns/1ps

`include "axi_xfer_settings.svh"

module axi_write_aligner (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  axi_xfer_pkg::xfer_geom_t geom_i,         // Stable for the whole transfer
   input  logic                     burst_go_i,     // AW of a burst accepted
   input  axi_xfer_pkg::cnt_t       burst_beats_i,
   input  logic                     src_valid_i,
   input  axi_xfer_pkg::data_t      src_data_i,
   output logic                     src_ready_o,
   output logic                     w_valid_o,
   input  logic                     w_ready_i,
   output axi_xfer_pkg::data_t      w_data_o,
   output axi_xfer_pkg::strb_t      w_strb_o,
   output logic                     w_last_o,
   output logic                     burst_done_o
);

   import axi_xfer_pkg::*;

   data_t       residue_q;    // Last source word taken
   cnt_t        xfer_beat_q;  // Beat index in the transfer
   cnt_t        burst_rem_q;  // Beats left in the burst
   logic        burst_act_q;

   logic        xfer_first;
   logic        xfer_last;
   logic        needs_src;    // Beat consumes a source word
   logic        w_hs;
   int unsigned lo_sh;        // Shift of the new word
   int unsigned hi_sh;        // Shift of the residue
   strb_t       head_strb;
   strb_t       tail_strb;

   assign xfer_first = (xfer_beat_q == '0);
   assign xfer_last  = (xfer_beat_q == geom_i.axi_beats - cnt_t'(1));

   // Extra beat is built from the residue only
   assign needs_src = !(geom_i.extra_beat && xfer_last);

   assign lo_sh = {geom_i.offset, 3'b000};
   assign hi_sh = `AXI_XFER_DATA_W - lo_sh;  // Full width when aligned, residue drops out

   // W waits for source data, source waits for W
   assign w_valid_o   = burst_act_q && (!needs_src || src_valid_i);
   assign src_ready_o = burst_act_q && needs_src && w_ready_i;
   assign w_hs        = w_valid_o && w_ready_i;

   // Low lanes from the old word, high lanes from the new one
   assign w_data_o = (needs_src ? (src_data_i << lo_sh) : '0) | (residue_q >> hi_sh);

   assign head_strb = xfer_first ? geom_i.initial_strb : '1;
   assign tail_strb = xfer_last  ? geom_i.final_strb   : '1;
   assign w_strb_o  = head_strb & tail_strb;  // Both apply on a one-beat transfer
   assign w_last_o  = (burst_rem_q == cnt_t'(1));

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         xfer_beat_q  <= '0;
         burst_rem_q  <= '0;
         burst_act_q  <= 1'b0;
         burst_done_o <= 1'b0;
      end else begin
         burst_done_o <= w_hs && w_last_o;  // One cycle after WLAST handshake

         if (burst_go_i) begin
            burst_act_q <= 1'b1;
            burst_rem_q <= burst_beats_i;
         end else if (w_hs) begin
            burst_rem_q <= burst_rem_q - cnt_t'(1);
            if (w_last_o) begin
               burst_act_q <= 1'b0;  // Hold W until the next AW
            end
         end

         // Wraps to zero ready for the next command
         if (w_hs) begin
            xfer_beat_q <= xfer_last ? '0 : xfer_beat_q + cnt_t'(1);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (w_hs && needs_src) begin
         residue_q <= src_data_i;
      end
   end

endmodule

// File: hdl/axi_burst_sequencer.sv
`timescale 1ns/1ps

module axi_burst_sequencer (
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      cmd_valid_i,
   output logic                      cmd_ready_o,
   input  axi_xfer_pkg::burst_info_t burst_i,
   output logic                      xfer_start_o,  // Controller loads the command
   output logic                      burst_adv_o,   // Controller steps to next burst
   output logic                      aw_valid_o,
   input  logic                      aw_ready_i,
   output axi_xfer_pkg::aw_beat_t    aw_o,
   output logic                      burst_go_o,
   output axi_xfer_pkg::cnt_t        burst_beats_o,
   input  logic                      burst_done_i,
   input  logic                      b_valid_i,
   output logic                      b_ready_o,
   input  axi_xfer_pkg::resp_t       b_resp_i,
   output logic                      done_o,
   output axi_xfer_pkg::resp_t       done_resp_o
);

   import axi_xfer_pkg::*;

   localparam resp_t RESP_OKAY = 2'b00;

   seq_state_t state_q;
   seq_state_t state_d;
   logic       last_q;   // Burst in flight closes the transfer
   resp_t      worst_q;  // Worst response of earlier bursts
   resp_t      worst_d;
   logic       aw_hs;
   logic       b_hs;

   assign xfer_start_o = cmd_valid_i && cmd_ready_o;

   assign aw_valid_o  = (state_q == ADDR);
   assign aw_hs       = aw_valid_o && aw_ready_i;
   assign burst_adv_o = aw_hs;
   assign burst_go_o  = aw_hs;  // W side starts with the address

   // Payload comes straight from the controller, steady until burst_adv
   assign aw_o.addr     = burst_i.addr;
   assign aw_o.len      = burst_i.len;
   assign aw_o.size     = AXSIZE_FULL;
   assign aw_o.burst    = BURST_INCR;
   assign burst_beats_o = cnt_t'(burst_i.len) + cnt_t'(1);

   assign b_ready_o = (state_q == RESP);
   assign b_hs      = b_valid_i && b_ready_o;

   // Codes rank by value, DECERR over SLVERR over OKAY
   assign worst_d = (b_resp_i > worst_q) ? b_resp_i : worst_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:    if (xfer_start_o) state_d = CALC;
         CALC:    state_d = ADDR;  // Burst info settles here
         ADDR:    if (aw_hs) state_d = DATA;
         DATA:    if (burst_done_i) state_d = RESP;
         RESP: begin
            if (b_hs) begin
               state_d = last_q ? IDLE : CALC;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q     <= IDLE;
         cmd_ready_o <= 1'b0;
         last_q      <= 1'b0;
         worst_q     <= RESP_OKAY;
         done_o      <= 1'b0;
         done_resp_o <= RESP_OKAY;
      end else begin
         state_q     <= state_d;
         cmd_ready_o <= (state_d == IDLE);  // Low for a cycle after reset
         done_o      <= b_hs && last_q;

         if (aw_hs) begin
            last_q <= burst_i.last;  // Controller moves on at this edge
         end

         if (xfer_start_o) begin
            worst_q <= RESP_OKAY;
         end else if (b_hs) begin
            worst_q <= worst_d;
         end

         if (b_hs && last_q) begin
            done_resp_o <= worst_d;  // Held until the next completion
         end
      end
   end

endmodule

// File: hdl/axi_write_dma.sv
`timescale 1ns/1ps

module axi_write_dma (
   input  logic                     clk_i,
   input  logic                     rst_i,
   // Command
   input  logic                     cmd_valid_i,
   output logic                     cmd_ready_o,
   input  axi_xfer_pkg::xfer_cmd_t  cmd_i,
   // Source stream, packed from lane 0
   input  logic                     src_valid_i,
   output logic                     src_ready_o,
   input  axi_xfer_pkg::data_t      src_data_i,
   // AXI write address
   output logic                     aw_valid_o,
   input  logic                     aw_ready_i,
   output axi_xfer_pkg::aw_beat_t   aw_o,
   // AXI write data
   output logic                     w_valid_o,
   input  logic                     w_ready_i,
   output axi_xfer_pkg::data_t      w_data_o,
   output axi_xfer_pkg::strb_t      w_strb_o,
   output logic                     w_last_o,
   // AXI write response
   input  logic                     b_valid_i,
   output logic                     b_ready_o,
   input  axi_xfer_pkg::resp_t      b_resp_i,
   // Completion
   output logic                     done_o,
   output axi_xfer_pkg::resp_t      done_resp_o
);

   import axi_xfer_pkg::*;

   logic        xfer_start;
   logic        burst_adv;
   burst_info_t burst_info;
   xfer_geom_t  geom;
   logic        burst_go;
   cnt_t        burst_beats;
   logic        burst_done;

   axi_transfer_ctrl i_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .xfer_start_i (xfer_start),
      .burst_adv_i  (burst_adv),
      .cmd_i        (cmd_i),
      .burst_o      (burst_info),
      .geom_o       (geom)
   );

   axi_burst_sequencer i_seq (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .cmd_valid_i   (cmd_valid_i),
      .cmd_ready_o   (cmd_ready_o),
      .burst_i       (burst_info),
      .xfer_start_o  (xfer_start),
      .burst_adv_o   (burst_adv),
      .aw_valid_o    (aw_valid_o),
      .aw_ready_i    (aw_ready_i),
      .aw_o          (aw_o),
      .burst_go_o    (burst_go),
      .burst_beats_o (burst_beats),
      .burst_done_i  (burst_done),
      .b_valid_i     (b_valid_i),
      .b_ready_o     (b_ready_o),
      .b_resp_i      (b_resp_i),
      .done_o        (done_o),
      .done_resp_o   (done_resp_o)
   );

   // Geometry goes to the aligner, it stays put through the transfer
   axi_write_aligner i_align (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .geom_i        (geom),
      .burst_go_i    (burst_go),
      .burst_beats_i (burst_beats),
      .src_valid_i   (src_valid_i),
      .src_data_i    (src_data_i),
      .src_ready_o   (src_ready_o),
      .w_valid_o     (w_valid_o),
      .w_ready_i     (w_ready_i),
      .w_data_o      (w_data_o),
      .w_strb_o      (w_strb_o),
      .w_last_o      (w_last_o),
      .burst_done_o  (burst_done)
   );

endmodule

// File: verification/axi_write_dma_tb.sv
`timescale 1ns/1ps

module axi_write_dma_tb;

   import axi_xfer_pkg::*;

   localparam int    NUM_ROWS   = 8;
   localparam int    RST_CYCLES = 5;
   localparam resp_t OKAY       = 2'b00;
   localparam resp_t SLVERR     = 2'b10;

   localparam logic [2:0] EXP_SIZE = 3'($clog2(STRB_W));  // log2 of bytes per beat
   localparam logic [1:0] EXP_INCR = 2'b01;

   typedef struct packed {
      addr_t addr;
      len_t  len;
      resp_t resp;  // B code of the first burst, later bursts get OKAY
   } row_t;

   row_t rows [NUM_ROWS] = '{
      '{32'h0000_1000, 16'd64,   OKAY},    // Aligned, one burst
      '{32'h0000_2003, 16'd37,   OKAY},    // Unaligned, beats equal words
      '{32'h0000_2101, 16'd2,    OKAY},    // Inside one word
      '{32'h0000_2203, 16'd3,    SLVERR},  // Sub-word spilling into a second beat
      '{32'h0000_4e01, 16'd1500, SLVERR},  // Page split first, error must stick
      '{32'h0000_6000, 16'd2048, OKAY},    // Two full 256 beat bursts
      '{32'h0000_7ffd, 16'd10,   OKAY},    // One beat left before the page edge
      '{32'h0000_a3fe, 16'd300,  OKAY}     // Extra beat at the tail
   };

   logic       clk_i = 1'b0;
   logic       rst_i;
   logic       cmd_valid_i, cmd_ready_o;
   xfer_cmd_t  cmd_i;
   logic       src_valid_i, src_ready_o;
   data_t      src_data_i;
   logic       aw_valid_o, aw_ready_i;
   aw_beat_t   aw_o;
   logic       w_valid_o, w_ready_i, w_last_o;
   data_t      w_data_o;
   strb_t      w_strb_o;
   logic       b_valid_i, b_ready_o;
   resp_t      b_resp_i;
   logic       done_o;
   resp_t      done_resp_o;

   integer     seed = 32'hcbf0_fea5;
   int         errors;
   int         cycles;
   int         cycle_limit = RST_CYCLES;
   data_t      src_q [$];             // Every source word of the run, in order
   logic [7:0] pat_base [NUM_ROWS];   // First pattern byte of each row
   logic [7:0] mem [addr_t];          // Slave memory, written bytes only
   logic [7:0] exp_mem [addr_t];
   logic       src_hs_q, b_hs_q;      // Handshakes seen at the last rising edge
   addr_t      wr_addr, next_aw_addr;
   addr_t      xfer_end;              // Word-rounded end of the running command
   addr_t      burst_end;             // Expected end of the burst just issued
   int         burst_left;            // W beats still owed to the open burst
   int         src_cnt, w_cnt, beat_sum, aw_cnt, wlast_cnt;
   int         cmd_cnt, done_cnt, b_acked, b_sent, b_base;
   resp_t      cur_resp;

   axi_write_dma i_dut (.*);

   always #2 clk_i = ~clk_i;  // 4 ns period

   // Bytes never written read back as a mix of the whole address
   function automatic logic [7:0] fill_byte(input addr_t a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
   endtask

   task automatic report_problem(input string what);
      $display("Error at %0t: %s", $time, what);
      errors++;
   endtask

   // Source words carry a running byte counter across all rows
   task automatic prepare_stimulus();
      logic [7:0] pat;
      data_t      word;
      pat = 8'h11;
      for (int r = 0; r < NUM_ROWS; r++) begin
         pat_base[r] = pat;
         for (int w = 0; w < (int'(rows[r].len) + STRB_W - 1) / STRB_W; w++) begin
            for (int b = 0; b < STRB_W; b++) begin
               word[8*b +: 8] = pat + 8'(w * STRB_W + b);
            end
            src_q.push_back(word);
         end
         pat         += 8'(rows[r].len);
         cycle_limit += (int'(rows[r].len) / STRB_W + 20) * 8;
      end
   endtask

   // Slave model and stream monitor on settled pre-edge values
   always @(posedge clk_i) begin
      src_hs_q = src_valid_i && src_ready_o;
      b_hs_q   = b_valid_i && b_ready_o;
      if (src_hs_q) src_cnt++;
      if (b_hs_q) b_acked++;
      if (cmd_valid_i && cmd_ready_o) cmd_cnt++;
      if (done_o === 1'b1) done_cnt++;
      if (aw_valid_o && aw_ready_i) begin
         assert (burst_left == 0 && b_acked == wlast_cnt)
            else report_problem("AW issued before the previous burst closed");
         assert (aw_o.addr == next_aw_addr)
            else report_mismatch("aw_o.addr", aw_o.addr, next_aw_addr);
         assert (aw_o.size == EXP_SIZE)
            else report_mismatch("aw_o.size", aw_o.size, EXP_SIZE);
         assert (aw_o.burst == EXP_INCR)
            else report_mismatch("aw_o.burst", aw_o.burst, EXP_INCR);
         assert (aw_o.addr[OFFSET_W-1:0] == '0)
            else report_problem("AW address not word aligned");
         assert (int'(aw_o.addr[11:0]) + (int'(aw_o.len) + 1) * STRB_W <= 4096)
            else report_problem("burst crosses a 4 KB boundary");
         // Burst runs to the nearest of 256 beats, the page end and the transfer end
         burst_end = aw_o.addr + addr_t'(256 * STRB_W);
         if ((aw_o.addr | addr_t'(32'hfff)) + addr_t'(1) < burst_end) begin
            burst_end = (aw_o.addr | addr_t'(32'hfff)) + addr_t'(1);
         end
         if (xfer_end < burst_end) begin
            burst_end = xfer_end;
         end
         assert (int'(aw_o.len) + 1 == int'(burst_end - aw_o.addr) / STRB_W)
            else report_mismatch("aw_o.len", aw_o.len,
                                 int'(burst_end - aw_o.addr) / STRB_W - 1);
         wr_addr      = aw_o.addr;
         burst_left   = int'(aw_o.len) + 1;
         beat_sum     += burst_left;
         next_aw_addr += addr_t'(burst_left * STRB_W);  // Bursts of a transfer are contiguous
         aw_cnt++;
      end
      if (w_valid_o && w_ready_i) begin
         w_cnt++;
         assert (burst_left != 0) else report_problem("W beat with no open burst");
         if (burst_left != 0) begin
            assert (w_last_o == (burst_left == 1))
               else report_mismatch("w_last_o", w_last_o, burst_left == 1);
            for (int l = 0; l < STRB_W; l++) begin
               if (w_strb_o[l]) mem[wr_addr + addr_t'(l)] = w_data_o[8*l +: 8];
            end
            wr_addr += addr_t'(STRB_W);
            burst_left--;
         end
         if (w_last_o) wlast_cnt++;  // B becomes due
      end
   end

   // Random ready and valid gaps; a raised valid holds until taken
   always @(negedge clk_i) begin
      aw_ready_i = ($random(seed) & 3) != 0;
      w_ready_i  = ($random(seed) & 3) != 0;
      if (!src_valid_i || src_hs_q) begin
         src_valid_i = (src_cnt < src_q.size()) && (($random(seed) & 3) != 0);
         src_data_i  = src_valid_i ? src_q[src_cnt] : '0;
      end
      if (!b_valid_i || b_hs_q) begin
         b_valid_i = (b_sent < wlast_cnt) && (($random(seed) & 3) != 0);
         b_resp_i  = (b_sent == b_base) ? cur_resp : OKAY;
         if (b_valid_i) b_sent++;
      end
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Timeout: no completion within %0d cycles", cycle_limit);
         $display("Commands %0d, bursts %0d, W beats %0d, errors %0d",
                  cmd_cnt, aw_cnt, w_cnt, errors);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic run_command(input int r);
      row_t       row;
      int         len, exp_words, exp_beats;
      int         w0, s0, bs0, d0, c0;
      addr_t      a;
      logic [7:0] got, want;
      row       = rows[r];
      len       = int'(row.len);
      exp_words = (len + STRB_W - 1) / STRB_W;
      exp_beats = (int'(row.addr[OFFSET_W-1:0]) + len + STRB_W - 1) / STRB_W;
      w0  = w_cnt;
      s0  = src_cnt;
      bs0 = beat_sum;
      d0  = done_cnt;
      c0  = cmd_cnt;
      next_aw_addr = row.addr & ~addr_t'(STRB_W - 1);
      xfer_end     = (row.addr + addr_t'(len) + addr_t'(STRB_W - 1)) & ~addr_t'(STRB_W - 1);
      cur_resp     = row.resp;
      b_base       = b_sent;
      cmd_i.addr   = row.addr;
      cmd_i.len    = row.len;
      cmd_valid_i  = 1'b1;
      while (cmd_cnt == c0) @(negedge clk_i);
      cmd_valid_i = 1'b0;
      while (done_cnt == d0) @(negedge clk_i);
      repeat (4) @(negedge clk_i);  // Room for a stray second pulse

      assert (done_cnt - d0 == 1)
         else report_mismatch("done_o pulses", done_cnt - d0, 1);
      assert (done_resp_o == row.resp)
         else report_mismatch("done_resp_o", done_resp_o, row.resp);
      assert (burst_left == 0) else report_problem("last burst ended with beats missing");
      assert (w_cnt - w0 == exp_beats)
         else report_mismatch("w_valid_o beats", w_cnt - w0, exp_beats);
      assert (beat_sum - bs0 == exp_beats)
         else report_mismatch("aw_o.len+1 sum", beat_sum - bs0, exp_beats);
      assert (src_cnt - s0 == exp_words)
         else report_mismatch("src_ready_o words", src_cnt - s0, exp_words);
      if (exp_beats != exp_words) begin
         assert (w_cnt - w0 == src_cnt - s0 + 1)
            else report_problem("unaligned tail produced no extra W beat");
      end

      // Written range plus one word on each side
      for (int i = 0; i < len; i++) begin
         exp_mem[row.addr + addr_t'(i)] = pat_base[r] + 8'(i);
      end
      for (int i = -STRB_W; i < len + STRB_W; i++) begin
         a    = row.addr + addr_t'(i);
         got  = mem.exists(a) ? mem[a] : fill_byte(a);
         want = exp_mem.exists(a) ? exp_mem[a] : fill_byte(a);
         assert (got == want) else report_mismatch($sformatf("mem[0x%08h]", a), got, want);
      end
   endtask

   initial begin
      rst_i       = 1'b1;
      cmd_valid_i = 1'b0;
      cmd_i       = '0;
      src_valid_i = 1'b0;
      src_data_i  = '0;
      aw_ready_i  = 1'b0;
      w_ready_i   = 1'b0;
      b_valid_i   = 1'b0;
      b_resp_i    = OKAY;
      prepare_stimulus();
      repeat (RST_CYCLES) @(negedge clk_i);
      assert (!(cmd_ready_o || aw_valid_o || w_valid_o || b_ready_o || src_ready_o || done_o))
         else report_problem("valid, ready or done output high during reset");
      rst_i = 1'b0;
      for (int r = 0; r < NUM_ROWS; r++) begin
         run_command(r);
      end
      assert (src_cnt == src_q.size())
         else report_mismatch("src_ready_o words total", src_cnt, src_q.size());
      $display("Commands %0d, bursts %0d, W beats %0d, errors %0d",
               cmd_cnt, aw_cnt, w_cnt, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: Bender.yml
package:
  name: axi_write_dma

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/axi_xfer_pkg.sv
      - hdl/axi_transfer_ctrl.sv
      - hdl/axi_write_aligner.sv
      - hdl/axi_burst_sequencer.sv
      - hdl/axi_write_dma.sv
  - target: test
    files:
      - verification/axi_write_dma_tb.sv

// File: tb.f
+incdir+include
hdl/axi_xfer_pkg.sv
hdl/axi_transfer_ctrl.sv
hdl/axi_write_aligner.sv
hdl/axi_burst_sequencer.sv
hdl/axi_write_dma.sv
verification/axi_write_dma_tb.sv
